/* hdl/secv_defines.svh */
// SEC-V core configuration macros shared by RTL and testbench
`ifndef SECV_DEFINES_SVH
`define SECV_DEFINES_SVH

// Datapath width
`define XLEN 64

// Request buffer depth, also the requester's initial credit count
`define CSR_CREDITS 4

// Default number of harts
`define HARTS 1

// Machine information registers
`define MVENDORID_VAL 64'h0000_0000_0000_0000  // Non-commercial implementation
`define MARCHID_VAL   64'h0000_0000_5345_4356  // "SECV" in ASCII
`define MIMPID_VAL    64'h0000_0000_0001_0000  // Implementation version 1.0

// MXL=2 (RV64) in bits 63:62, I in bit 8, U in bit 20
`define MISA_VAL 64'h8000_0000_0010_0100

`endif

/* hdl/secv_pkg.sv */
// SEC-V core-wide types for data words, hart ids and trap events
`include "secv_defines.svh"

package secv_pkg;

    // Hart id width, never below one bit
    localparam int HARTID_W = (`HARTS > 1) ? $clog2(`HARTS) : 1;

    typedef logic [`XLEN-1:0]    xlen_t;          // Architectural data word
    typedef logic [HARTID_W-1:0] hartid_t;        // Hardware thread id

    typedef logic [3:0] intr_cause_t;             // Interrupt cause code
    typedef logic [3:0] excpt_cause_t;            // Exception cause code

    // Trap event from the pipeline, sampled at the clock edge
    typedef struct packed {
        logic         valid;                      // Trap taken this cycle
        logic         is_intr;                    // Interrupt, else exception
        intr_cause_t  intr_cause;                 // Used when is_intr set
        excpt_cause_t excpt_cause;                // Used when is_intr clear
        xlen_t        pc;                         // PC of trapping instruction
        xlen_t        tval;                       // Faulting address or opcode
    } trap_t;

endpackage

/* hdl/csr_pkg.sv */
// Zicsr types for requests, responses, the write port and mstatus layout
`include "secv_defines.svh"

package csr_pkg;

    import secv_pkg::*;

    typedef logic [11:0] csr_addr_t;              // CSR address space

    // Operation code, zero is unused
    typedef logic [1:0] csr_op_t;
    localparam csr_op_t CSR_OP_RW = 2'd1;         // CSRRW
    localparam csr_op_t CSR_OP_RS = 2'd2;         // CSRRS
    localparam csr_op_t CSR_OP_RC = 2'd3;         // CSRRC

    // Machine trap setup
    localparam csr_addr_t CSR_ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_ADDR_MISA      = 12'h301;
    localparam csr_addr_t CSR_ADDR_MIE       = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC     = 12'h305;

    // Machine trap handling
    localparam csr_addr_t CSR_ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_ADDR_MIP       = 12'h344;

    // Machine counters
    localparam csr_addr_t CSR_ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t CSR_ADDR_MINSTRET  = 12'hB02;

    // Machine information, read-only
    localparam csr_addr_t CSR_ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_ADDR_MHARTID   = 12'hF14;

    // Write masks
    localparam xlen_t MSTATUS_WMASK = 64'h0000_0000_0000_1888;  // MPP, MPIE, MIE
    localparam xlen_t MTVEC_WMASK   = ~64'h2;                   // Reserved mode bit
    localparam xlen_t MEPC_WMASK    = ~64'h1;                   // Halfword aligned

    typedef struct packed {
        logic      valid;                         // Request present
        csr_op_t   op;                            // RW, RS or RC
        csr_addr_t addr;                          // Target CSR
        xlen_t     wdata;                         // Source operand
    } csr_req_t;

    typedef struct packed {
        logic  valid;                             // One cycle per request
        logic  err;                               // Illegal access
        xlen_t rdata;                             // Old CSR value
    } csr_rsp_t;

    typedef struct packed {
        logic      en;                            // Commit at next edge
        csr_addr_t addr;
        xlen_t     data;                          // Value before field masking
    } csr_wr_t;

    typedef struct packed {
        logic [50:0] rsvd_63_13;
        logic [1:0]  mpp;                         // Previous privilege
        logic [2:0]  rsvd_10_8;
        logic        mpie;                        // Previous MIE
        logic [2:0]  rsvd_6_4;
        logic        mie;                         // Global M-mode IRQ enable
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

endpackage

/* hdl/csr_req_fifo.sv */
// CSR request buffer sized to the credit count, returns a credit per pop
`timescale 1ns/1ps
`include "secv_defines.svh"

module csr_req_fifo import csr_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  csr_req_t req_i,                       // Valid only while holding a credit
    input  logic     pop_i,                       // Consume head entry
    output csr_req_t head_o,                      // Oldest entry, valid when non-empty
    output logic     credit_o                     // One pulse per popped entry
);

    localparam int DEPTH = `CSR_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    csr_req_t          mem [DEPTH];               // Entry storage
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;                     // Occupancy
    logic              not_empty;
    logic              full;
    logic              push;
    logic              pop;

    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign push      = req_i.valid && !full;      // Never full with correct credit use
    assign pop       = pop_i && not_empty;

    assign head_o   = '{valid: not_empty, op: mem[rd_ptr].op,
                        addr: mem[rd_ptr].addr, wdata: mem[rd_ptr].wdata};
    assign credit_o = pop;                        // Slot freed, hand credit back

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= req_i;                 // Payload only, no reset
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);  // Simultaneous push/pop holds
        end
    end

endmodule

/* hdl/csr_access_ctrl.sv */
// CSR read-modify-write stage with illegal access detection and response register
`timescale 1ns/1ps

module csr_access_ctrl import secv_pkg::*, csr_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,

    // Request buffer head
    input  csr_req_t  head_i,
    output logic      pop_o,                      // Take head this cycle

    // Register file read port
    output csr_addr_t rd_addr_o,
    input  xlen_t     rd_data_i,                  // Value before this cycle's write
    input  logic      rd_known_i,                 // Address implemented

    // Register file write port
    output csr_wr_t   wr_o,

    // Response to requester
    output csr_rsp_t  rsp_o
);

    xlen_t new_val;                               // Result of the operation
    logic  bad_op;                                // Op code 0
    logic  op_writes;                             // Access modifies the CSR
    logic  ro_addr;                               // addr[11:10] == 2'b11
    logic  err;

    logic  rsp_valid_q;
    logic  rsp_err_q;
    xlen_t rsp_rdata_q;

    // One request per cycle, single stage
    assign pop_o     = head_i.valid;
    assign rd_addr_o = head_i.addr;

    always_comb begin
        bad_op = 1'b0;
        case (head_i.op)
            CSR_OP_RW: new_val = head_i.wdata;                  // Swap
            CSR_OP_RS: new_val = rd_data_i | head_i.wdata;      // Set bits
            CSR_OP_RC: new_val = rd_data_i & ~head_i.wdata;     // Clear bits
            default: begin
                new_val = rd_data_i;
                bad_op  = 1'b1;
            end
        endcase
    end

    // RS/RC with a zero operand leave the CSR untouched, so they act as pure reads
    assign op_writes = (head_i.op == CSR_OP_RW) || (head_i.wdata != '0);
    assign ro_addr   = (head_i.addr[11:10] == 2'b11);
    assign err       = !rd_known_i || bad_op || (ro_addr && op_writes);

    // Write suppressed on error
    assign wr_o = '{en:   head_i.valid && op_writes && !err,
                    addr: head_i.addr,
                    data: new_val};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
            rsp_err_q   <= 1'b0;
        end else begin
            rsp_valid_q <= head_i.valid;
            rsp_err_q   <= head_i.valid && err;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_rdata_q <= err ? '0 : rd_data_i;      // Old value, zero on error
    end

    assign rsp_o = '{valid: rsp_valid_q, err: rsp_err_q, rdata: rsp_rdata_q};

endmodule

/* hdl/csr_regs.sv */
// Machine-mode CSR file with read decode, write port, trap capture and counters
`timescale 1ns/1ps
`include "secv_defines.svh"

module csr_regs import secv_pkg::*, csr_pkg::*; #(
    parameter int HARTS = `HARTS
) (
    input  logic      clk_i,
    input  logic      rst_i,

    input  hartid_t   hartid_i,                   // Hardware thread id

    // Read port, combinational
    input  csr_addr_t rd_addr_i,
    output xlen_t     rd_data_o,
    output logic      rd_known_o,                 // Address decoded

    // Write port, committed at the clock edge
    input  csr_wr_t   wr_i,

    // Trap and retire events
    input  trap_t     trap_i,
    input  logic      retire_i                    // One instruction retired
);

    localparam int    HID_W       = (HARTS > 1) ? $clog2(HARTS) : 1;
    localparam xlen_t HARTID_MASK = xlen_t'((65'd1 << HID_W) - 65'd1);

    // Machine mode state
    mstatus_t mstatus;                            // Machine status
    xlen_t    mie;                                // Interrupt enable
    xlen_t    mtvec;                              // Trap vector base
    xlen_t    mscratch;                           // Scratch
    xlen_t    mepc;                               // Exception PC
    xlen_t    mcause;                             // Trap cause
    xlen_t    mtval;                              // Trap value
    xlen_t    mcycle;                             // Cycle counter
    xlen_t    minstret;                           // Retired instructions

    xlen_t      mhartid;
    logic [3:0] trap_cause;                       // Selected cause code

    // Only ids of the configured hart count are visible
    assign mhartid    = xlen_t'(hartid_i) & HARTID_MASK;
    assign trap_cause = trap_i.is_intr ? trap_i.intr_cause : trap_i.excpt_cause;

    always_comb begin
        rd_data_o  = '0;
        rd_known_o = 1'b1;
        case (rd_addr_i)
            CSR_ADDR_MSTATUS:   rd_data_o = mstatus;
            CSR_ADDR_MISA:      rd_data_o = `MISA_VAL;        // Constant ISA
            CSR_ADDR_MIE:       rd_data_o = mie;
            CSR_ADDR_MTVEC:     rd_data_o = mtvec;
            CSR_ADDR_MSCRATCH:  rd_data_o = mscratch;
            CSR_ADDR_MEPC:      rd_data_o = mepc;
            CSR_ADDR_MCAUSE:    rd_data_o = mcause;
            CSR_ADDR_MTVAL:     rd_data_o = mtval;
            CSR_ADDR_MIP:       rd_data_o = '0;               // No pending sources
            CSR_ADDR_MCYCLE:    rd_data_o = mcycle;
            CSR_ADDR_MINSTRET:  rd_data_o = minstret;
            CSR_ADDR_MVENDORID: rd_data_o = `MVENDORID_VAL;
            CSR_ADDR_MARCHID:   rd_data_o = `MARCHID_VAL;
            CSR_ADDR_MIMPID:    rd_data_o = `MIMPID_VAL;
            CSR_ADDR_MHARTID:   rd_data_o = mhartid;
            default:            rd_known_o = 1'b0;            // Unimplemented
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            // Free-running counters, overridden by a CSR write below
            mcycle   <= mcycle + 1'b1;
            minstret <= minstret + xlen_t'(retire_i);

            if (wr_i.en) begin
                case (wr_i.addr)
                    CSR_ADDR_MSTATUS:  mstatus  <= mstatus_t'(wr_i.data & MSTATUS_WMASK);
                    CSR_ADDR_MIE:      mie      <= wr_i.data;
                    CSR_ADDR_MTVEC:    mtvec    <= wr_i.data & MTVEC_WMASK;
                    CSR_ADDR_MSCRATCH: mscratch <= wr_i.data;
                    CSR_ADDR_MEPC:     mepc     <= wr_i.data & MEPC_WMASK;
                    CSR_ADDR_MCAUSE:   mcause   <= wr_i.data;
                    CSR_ADDR_MTVAL:    mtval    <= wr_i.data;
                    CSR_ADDR_MCYCLE:   mcycle   <= wr_i.data;    // Write beats increment
                    CSR_ADDR_MINSTRET: minstret <= wr_i.data;
                    default: ;                                   // misa, mip, IDs ignore
                endcase
            end

            // Trap comes last so it wins over a same-cycle write
            if (trap_i.valid) begin
                mepc         <= trap_i.pc & MEPC_WMASK;
                mtval        <= trap_i.tval;
                mcause       <= {trap_i.is_intr, {(`XLEN-5){1'b0}}, trap_cause};
                mstatus      <= '0;                              // Reserved bits stay zero
                mstatus.mpie <= mstatus.mie;                     // Stack enable
                mstatus.mie  <= 1'b0;                            // Mask interrupts
                mstatus.mpp  <= 2'b11;                           // Came from M-mode
            end
        end
    end

endmodule

/* hdl/csr_unit_top.sv */
// Zicsr unit top connecting request buffer, access stage and CSR file
`timescale 1ns/1ps
`include "secv_defines.svh"

module csr_unit_top import secv_pkg::*, csr_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  hartid_t  hartid_i,
    input  csr_req_t req_i,                       // Credit-controlled requests
    output logic     credit_o,                    // Credit return pulse
    output csr_rsp_t rsp_o,                       // Two cycles after request
    input  trap_t    trap_i,
    input  logic     retire_i
);

    csr_req_t  head;                              // Buffer head entry
    logic      pop;
    csr_addr_t rd_addr;
    xlen_t     rd_data;
    logic      rd_known;
    csr_wr_t   wr;

    csr_req_fifo u_req_fifo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .pop_i    (pop),
        .head_o   (head),
        .credit_o (credit_o)
    );

    csr_access_ctrl u_access_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .head_i     (head),
        .pop_o      (pop),
        .rd_addr_o  (rd_addr),
        .rd_data_i  (rd_data),
        .rd_known_i (rd_known),
        .wr_o       (wr),
        .rsp_o      (rsp_o)
    );

    csr_regs #(
        .HARTS (`HARTS)
    ) u_csr_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .hartid_i   (hartid_i),
        .rd_addr_i  (rd_addr),
        .rd_data_o  (rd_data),
        .rd_known_o (rd_known),
        .wr_i       (wr),
        .trap_i     (trap_i),
        .retire_i   (retire_i)
    );

endmodule

/* tests/csr_tb.sv */
// Directed testbench for the Zicsr unit with a reference register model
`timescale 1ns/1ps
`include "secv_defines.svh"

module csr_tb import secv_pkg::*, csr_pkg::*; ();

    localparam int NUM_REQS = 55;                 // Requests issued over all tests

    typedef struct packed {
        logic        err;
        logic        chk;                         // Compare rdata
        xlen_t       data;
        logic [31:0] due;                         // Cycle the response must show up
    } exp_t;

    logic     clk_i;
    logic     rst_i;
    hartid_t  hartid_i;
    csr_req_t req_i;
    logic     credit_o;
    csr_rsp_t rsp_o;
    trap_t    trap_i;
    logic     retire_i;

    xlen_t       model [4096];                    // Expected CSR contents
    exp_t        exp_q [$];                       // Outstanding responses, oldest first
    logic [15:0] lfsr = 16'd57495;
    int          cyc;                             // Edge counter
    int          credits;
    int          credit_cnt;                      // Credit pulses seen
    int          req_cnt;
    int          last_issue;                      // Cycle of the latest request
    xlen_t       got_data;                        // Data of the latest response

    csr_unit_top DUT (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .hartid_i (hartid_i),
        .req_i    (req_i),
        .credit_o (credit_o),
        .rsp_o    (rsp_o),
        .trap_i   (trap_i),
        .retire_i (retire_i)
    );

    always #10 clk_i = ~clk_i;
    always @(posedge clk_i) cyc <= cyc + 1;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic check(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic xlen_t rand_bits(input int n);
        xlen_t v;
        logic  b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = b ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[62:0], b};
        end
        return v;
    endfunction

    function automatic logic is_known(input csr_addr_t a);
        case (a)
            CSR_ADDR_MSTATUS, CSR_ADDR_MISA, CSR_ADDR_MIE, CSR_ADDR_MTVEC,
            CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC, CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL,
            CSR_ADDR_MIP, CSR_ADDR_MCYCLE, CSR_ADDR_MINSTRET, CSR_ADDR_MVENDORID,
            CSR_ADDR_MARCHID, CSR_ADDR_MIMPID, CSR_ADDR_MHARTID: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic xlen_t wmask(input csr_addr_t a);
        case (a)
            CSR_ADDR_MSTATUS: return 64'h1888;    // MPP, MPIE, MIE
            CSR_ADDR_MTVEC:   return ~64'h2;      // Mode bit 1 reserved
            CSR_ADDR_MEPC:    return ~64'h1;
            CSR_ADDR_MIE, CSR_ADDR_MSCRATCH, CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL: return '1;
            default:          return '0;          // Constant, zero or read-only
        endcase
    endfunction

    task automatic send(input csr_op_t op, input csr_addr_t addr, input xlen_t wdata,
                        input logic exp_err, input logic chk, input xlen_t exp_data);
        @(posedge clk_i);
        while (credits == 0) begin                // Hold off until a credit returns
            req_i.valid <= 1'b0;
            @(posedge clk_i);
        end
        req_i      <= '{valid: 1'b1, op: op, addr: addr, wdata: wdata};
        credits    = credits - 1;
        last_issue = cyc;
        req_cnt    = req_cnt + 1;
        exp_q.push_back('{err: exp_err, chk: chk, data: exp_data, due: cyc + 3});
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            req_i.valid <= 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) @(posedge clk_i);
    endtask

    // Request checked against the model, model then takes the masked result
    task automatic access(input csr_op_t op, input csr_addr_t addr, input xlen_t wdata);
        logic  writes;
        logic  err;
        xlen_t nv;
        writes = (op == CSR_OP_RW) || (wdata != '0);   // RS/RC with zero only read
        err    = !is_known(addr) || ((addr[11:10] == 2'b11) && writes);
        send(op, addr, wdata, err, 1'b1, err ? '0 : model[addr]);
        if (!err && writes) begin
            case (op)
                CSR_OP_RW: nv = wdata;
                CSR_OP_RS: nv = model[addr] | wdata;
                default:   nv = model[addr] & ~wdata;
            endcase
            model[addr] = (model[addr] & ~wmask(addr)) | (nv & wmask(addr));
        end
    endtask

    task automatic reset_values();
        csr_addr_t regs [8] = '{CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC, CSR_ADDR_MCAUSE,
                                CSR_ADDR_MHARTID, CSR_ADDR_MVENDORID, CSR_ADDR_MARCHID,
                                CSR_ADDR_MIMPID, CSR_ADDR_MISA};
        foreach (regs[i]) access(CSR_OP_RS, regs[i], '0);
        drain();
    endtask

    task automatic rmw();
        for (int i = 0; i < 12; i++) begin
            access(csr_op_t'(i % 3 + 1), i[0] ? CSR_ADDR_MTVEC : CSR_ADDR_MSCRATCH,
                   rand_bits(64));
        end
        access(CSR_OP_RS, CSR_ADDR_MSCRATCH, '0);
        access(CSR_OP_RS, CSR_ADDR_MTVEC, '0);
        drain();
    endtask

    task automatic errors();
        access(CSR_OP_RW, CSR_ADDR_MVENDORID, rand_bits(64));
        access(CSR_OP_RS, CSR_ADDR_MVENDORID, '0);     // Still the ID value
        access(CSR_OP_RC, CSR_ADDR_MARCHID, 64'hFF);
        access(CSR_OP_RS, 12'h7C0, '0);                // Unsupported address
        access(CSR_OP_RW, 12'h123, rand_bits(64));
        access(CSR_OP_RS, CSR_ADDR_MARCHID, '0);
        drain();
    endtask

    task automatic burst();
        int c0;
        int r0;
        c0 = credit_cnt;
        r0 = req_cnt;
        for (int i = 0; i < 3 * `CSR_CREDITS; i++) begin
            access(csr_op_t'(i % 3 + 1), CSR_ADDR_MSCRATCH, rand_bits(64));
        end
        drain();
        check("credit_o pulses", xlen_t'(credit_cnt - c0), xlen_t'(req_cnt - r0));
    endtask

    task automatic take_trap(input logic intr, input logic [3:0] cause);
        trap_t t;
        xlen_t mpie;
        access(CSR_OP_RW, CSR_ADDR_MSTATUS, 64'h8);    // MIE set before the trap
        drain();
        t         = '0;
        t.valid   = 1'b1;
        t.is_intr = intr;
        t.intr_cause  = intr ? cause : ~cause;         // Unused field carries another code
        t.excpt_cause = intr ? ~cause : cause;
        t.pc      = rand_bits(64);
        t.tval    = rand_bits(64);
        @(posedge clk_i);
        trap_i <= t;
        @(posedge clk_i);
        trap_i <= '0;
        mpie = xlen_t'(model[CSR_ADDR_MSTATUS][3]);
        model[CSR_ADDR_MEPC]    = t.pc & ~64'h1;
        model[CSR_ADDR_MTVAL]   = t.tval;
        model[CSR_ADDR_MCAUSE]  = {intr, 59'd0, cause};
        model[CSR_ADDR_MSTATUS] = (mpie << 7) | 64'h1800;  // MPP = M, MIE cleared
        access(CSR_OP_RS, CSR_ADDR_MEPC, '0);
        access(CSR_OP_RS, CSR_ADDR_MTVAL, '0);
        access(CSR_OP_RS, CSR_ADDR_MSTATUS, '0);
        access(CSR_OP_RS, CSR_ADDR_MCAUSE, '0);
        drain();
    endtask

    task automatic counters();
        xlen_t v1;
        xlen_t w;
        int    i1;
        int    r;
        send(CSR_OP_RS, CSR_ADDR_MCYCLE, '0, 1'b0, 1'b0, '0);
        drain();
        v1 = got_data;
        i1 = last_issue;
        idle(int'(rand_bits(4)) + 2);
        send(CSR_OP_RS, CSR_ADDR_MCYCLE, '0, 1'b0, 1'b0, '0);
        drain();
        check("mcycle delta", got_data - v1, xlen_t'(last_issue - i1));
        r = int'(rand_bits(3)) + 1;
        repeat (r) begin
            @(posedge clk_i);
            retire_i <= 1'b1;
            @(posedge clk_i);
            retire_i <= 1'b0;
        end
        send(CSR_OP_RS, CSR_ADDR_MINSTRET, '0, 1'b0, 1'b1, xlen_t'(r));
        drain();
        w = rand_bits(48);
        send(CSR_OP_RW, CSR_ADDR_MCYCLE, w, 1'b0, 1'b0, '0);
        i1 = last_issue;
        idle(3);
        send(CSR_OP_RS, CSR_ADDR_MCYCLE, '0, 1'b0, 1'b0, '0);
        drain();
        // Write lands one edge before the read's buffer edge when back to back
        check("mcycle after write", got_data, w + xlen_t'(last_issue - i1 - 1));
    endtask

    // Responses and credit pulses sampled mid-cycle where they are stable
    always @(negedge clk_i) begin
        exp_t e;
        if (!rst_i) begin
            if (credit_o) begin
                credits    = credits + 1;
                credit_cnt = credit_cnt + 1;
            end
            if (rsp_o.valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("A response arrived with no request outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check("rsp_o.err", xlen_t'(rsp_o.err), xlen_t'(e.err));
                    if (e.chk) check("rsp_o.rdata", rsp_o.rdata, e.data);
                    check("rsp_o cycle", xlen_t'(cyc), xlen_t'(e.due));
                    got_data = rsp_o.rdata;
                end
            end
        end
    end

    initial begin
        repeat (NUM_REQS * 10 + 1000) @(posedge clk_i);
        fail_run("Timeout, the tests did not finish in time");
    end

    initial begin
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        hartid_i   = 1'b1;
        req_i      = '0;
        trap_i     = '0;
        retire_i   = 1'b0;
        cyc        = 0;
        credits    = `CSR_CREDITS;
        credit_cnt = 0;
        req_cnt    = 0;
        foreach (model[a]) model[a] = '0;
        model[CSR_ADDR_MISA]      = `MISA_VAL;
        model[CSR_ADDR_MVENDORID] = `MVENDORID_VAL;
        model[CSR_ADDR_MARCHID]   = `MARCHID_VAL;
        model[CSR_ADDR_MIMPID]    = `MIMPID_VAL;
        model[CSR_ADDR_MHARTID]   = 64'd1;        // Matches hartid_i
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        reset_values();
        rmw();
        errors();
        burst();
        take_trap(1'b0, 4'd2);                    // Illegal instruction
        take_trap(1'b1, 4'd7);                    // Machine timer interrupt
        counters();
        check("total credit_o pulses", xlen_t'(credit_cnt), xlen_t'(req_cnt));
        $display("sim passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+hdl
hdl/secv_pkg.sv
hdl/csr_pkg.sv
hdl/csr_req_fifo.sv
hdl/csr_access_ctrl.sv
hdl/csr_regs.sv
hdl/csr_unit_top.sv
tests/csr_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps
TOP       = csr_tb
FILELIST  = list.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
